// File: verilog/decode_pkg.sv
package decode_pkg;

  localparam int WORD_W    = 32;
  localparam int NUM_GREGS = 16;
  localparam int NUM_PREGS = 4;

  typedef logic [WORD_W-1:0]            word_t;
  typedef logic [$clog2(NUM_GREGS)-1:0] greg_idx_t;
  typedef logic [$clog2(NUM_PREGS)-1:0] preg_idx_t;
  typedef logic [3:0]                   alu_op_t;

  // instruction word layout
  localparam int GUARD_EN_BIT  = 31;
  localparam int GUARD_IDX_MSB = 30;
  localparam int GUARD_IDX_LSB = 29;
  localparam int OPC_MSB       = 28;
  localparam int OPC_LSB       = 23;
  localparam int Z_MSB         = 22;
  localparam int Z_LSB         = 19;
  localparam int Y_MSB         = 18;
  localparam int Y_LSB         = 15;
  localparam int XA_MSB        = 14; // alternate x field
  localparam int XA_LSB        = 11;

  typedef enum logic [5:0] {
    op_neg    = 6'h05,
    op_not    = 6'h06,
    op_and    = 6'h07,
    op_or     = 6'h08,
    op_xor    = 6'h09,
    op_add    = 6'h0a,
    op_sub    = 6'h0b,
    op_mul    = 6'h0c,
    op_div    = 6'h0d,
    op_mod    = 6'h0e,
    op_shl    = 6'h0f,
    op_shr    = 6'h10,
    op_andi   = 6'h11,
    op_ori    = 6'h12,
    op_xori   = 6'h13,
    op_addi   = 6'h14,
    op_subi   = 6'h15,
    op_muli   = 6'h16,
    op_divi   = 6'h17,
    op_modi   = 6'h18,
    op_shli   = 6'h19,
    op_shri   = 6'h1a,
    op_jali   = 6'h1b,
    op_jalr   = 6'h1c,
    op_jmpi   = 6'h1d,
    op_jmpr   = 6'h1e,
    op_ld     = 6'h23,
    op_st     = 6'h24,
    op_ldi    = 6'h25,
    op_rtop   = 6'h26,
    op_andp   = 6'h27,
    op_orp    = 6'h28,
    op_xorp   = 6'h29,
    op_notp   = 6'h2a,
    op_isneg  = 6'h2b,
    op_iszero = 6'h2c
  } opcode_e;

  typedef enum logic [1:0] {
    imm_none = 2'd0,
    imm_15   = 2'd1, // bits 14..0
    imm_23   = 2'd2, // bits 22..0
    imm_19   = 2'd3  // bits 18..0
  } imm_fmt_e;

  typedef struct packed {
    logic    link;
    logic    src2_imm;
    alu_op_t alu_op;
    logic    pf_or_int;
  } ex_ctrl_t;

  typedef struct packed {
    logic mem_write;
    logic mem_read;
  } mem_ctrl_t;

  typedef struct packed {
    logic rw_greg;
    logic rw_preg;
    logic from_mem;
  } wb_ctrl_t;

  typedef struct packed {
    logic reg_target;
    logic is_jump;
  } jmp_ctrl_t;

  typedef struct packed {
    logic      has_rx;
    logic      has_ry;
    wb_ctrl_t  wb;
    mem_ctrl_t mem;
    ex_ctrl_t  ex;
    jmp_ctrl_t jmp;
    imm_fmt_e  imm_fmt;
    logic      x_from_z;
  } ctrl_t;

  typedef struct packed {
    logic      en;
    greg_idx_t idx;
    word_t     data;
  } greg_wr_t;

  typedef struct packed {
    logic      en;
    preg_idx_t idx;
    logic      data;
  } preg_wr_t;

endpackage

// File: verilog/control_decoder.sv
module control_decoder (
  input  decode_pkg::opcode_e opcode,
  output decode_pkg::ctrl_t   ctrl
);

  always_comb
  begin
    ctrl = '0; // anything not listed is a nop
    case (opcode)
      decode_pkg::op_ld:
      begin
        ctrl.has_ry = 1'b1; // base register
        ctrl.wb.rw_greg = 1'b1;
        ctrl.wb.from_mem = 1'b1;
        ctrl.mem.mem_read = 1'b1;
        ctrl.ex.src2_imm = 1'b1;
        ctrl.ex.pf_or_int = 1'b1;
        ctrl.imm_fmt = decode_pkg::imm_15;
      end
      decode_pkg::op_st:
      begin
        ctrl.has_rx = 1'b1;
        ctrl.has_ry = 1'b1;
        ctrl.mem.mem_write = 1'b1;
        ctrl.ex.src2_imm = 1'b1;
        ctrl.ex.pf_or_int = 1'b1;
        ctrl.imm_fmt = decode_pkg::imm_15;
        ctrl.x_from_z = 1'b1; // store data sits in z
      end
      decode_pkg::op_andp, decode_pkg::op_orp, decode_pkg::op_xorp, decode_pkg::op_notp:
        ctrl.wb.rw_preg = 1'b1;
      decode_pkg::op_rtop, decode_pkg::op_isneg, decode_pkg::op_iszero:
      begin
        ctrl.has_ry = 1'b1;
        ctrl.wb.rw_preg = 1'b1;
      end
      decode_pkg::op_ldi:
      begin
        ctrl.wb.rw_greg = 1'b1;
        ctrl.ex.src2_imm = 1'b1;
        ctrl.ex.pf_or_int = 1'b1;
        ctrl.imm_fmt = decode_pkg::imm_19;
      end
      decode_pkg::op_addi, decode_pkg::op_subi, decode_pkg::op_muli, decode_pkg::op_divi,
      decode_pkg::op_modi, decode_pkg::op_shli, decode_pkg::op_shri, decode_pkg::op_andi,
      decode_pkg::op_ori, decode_pkg::op_xori:
      begin
        ctrl.has_ry = 1'b1;
        ctrl.wb.rw_greg = 1'b1;
        ctrl.ex.src2_imm = 1'b1;
        ctrl.ex.pf_or_int = 1'b1;
        ctrl.imm_fmt = decode_pkg::imm_15;
      end
      decode_pkg::op_add, decode_pkg::op_sub, decode_pkg::op_mul, decode_pkg::op_div,
      decode_pkg::op_mod, decode_pkg::op_shl, decode_pkg::op_shr, decode_pkg::op_and,
      decode_pkg::op_or, decode_pkg::op_xor:
      begin
        ctrl.has_rx = 1'b1;
        ctrl.has_ry = 1'b1;
        ctrl.wb.rw_greg = 1'b1;
        ctrl.ex.pf_or_int = 1'b1;
      end
      decode_pkg::op_neg, decode_pkg::op_not:
      begin
        ctrl.has_ry = 1'b1;
        ctrl.wb.rw_greg = 1'b1;
        ctrl.ex.pf_or_int = 1'b1;
      end
      decode_pkg::op_jmpi:
      begin
        ctrl.jmp.is_jump = 1'b1;
        ctrl.imm_fmt = decode_pkg::imm_23; // pc relative
      end
      decode_pkg::op_jmpr:
      begin
        ctrl.has_rx = 1'b1;
        ctrl.jmp.reg_target = 1'b1;
        ctrl.jmp.is_jump = 1'b1;
        ctrl.x_from_z = 1'b1;
      end
      decode_pkg::op_jali:
      begin
        ctrl.wb.rw_greg = 1'b1; // return address
        ctrl.ex.link = 1'b1;
        ctrl.ex.pf_or_int = 1'b1;
        ctrl.jmp.is_jump = 1'b1;
        ctrl.imm_fmt = decode_pkg::imm_19;
      end
      decode_pkg::op_jalr:
      begin
        ctrl.has_rx = 1'b1;
        ctrl.wb.rw_greg = 1'b1;
        ctrl.ex.link = 1'b1;
        ctrl.ex.pf_or_int = 1'b1;
        ctrl.jmp.reg_target = 1'b1;
        ctrl.jmp.is_jump = 1'b1;
      end
      default: ;
    endcase

    // alu code shared by the immediate and register forms
    case (opcode)
      decode_pkg::op_ld, decode_pkg::op_st, decode_pkg::op_andp, decode_pkg::op_addi,
      decode_pkg::op_add:                                          ctrl.ex.alu_op = 4'h1;
      decode_pkg::op_orp, decode_pkg::op_subi, decode_pkg::op_sub: ctrl.ex.alu_op = 4'h2;
      decode_pkg::op_xorp, decode_pkg::op_muli, decode_pkg::op_mul: ctrl.ex.alu_op = 4'h3;
      decode_pkg::op_notp, decode_pkg::op_divi, decode_pkg::op_div: ctrl.ex.alu_op = 4'h4;
      decode_pkg::op_rtop, decode_pkg::op_modi, decode_pkg::op_mod: ctrl.ex.alu_op = 4'h5;
      decode_pkg::op_isneg, decode_pkg::op_shli, decode_pkg::op_shl: ctrl.ex.alu_op = 4'h6;
      decode_pkg::op_iszero, decode_pkg::op_shri, decode_pkg::op_shr: ctrl.ex.alu_op = 4'h7;
      decode_pkg::op_andi, decode_pkg::op_and:                     ctrl.ex.alu_op = 4'h8;
      decode_pkg::op_ori, decode_pkg::op_or:                       ctrl.ex.alu_op = 4'h9;
      decode_pkg::op_xori, decode_pkg::op_xor:                     ctrl.ex.alu_op = 4'ha;
      decode_pkg::op_neg:                                          ctrl.ex.alu_op = 4'hb;
      decode_pkg::op_not:                                          ctrl.ex.alu_op = 4'hc;
      decode_pkg::op_ldi:                                          ctrl.ex.alu_op = 4'hd;
      decode_pkg::op_jali, decode_pkg::op_jalr:                    ctrl.ex.alu_op = 4'he;
      default: ;
    endcase
  end

endmodule

// File: verilog/gen_reg_file.sv
module gen_reg_file (
  input  logic                  clk,
  input  logic                  rst,
  input  decode_pkg::greg_wr_t  wr,
  input  decode_pkg::greg_idx_t x_idx,
  input  decode_pkg::greg_idx_t y_idx,
  output decode_pkg::word_t     rx,
  output decode_pkg::word_t     ry
);

  decode_pkg::word_t regs [decode_pkg::NUM_GREGS];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < decode_pkg::NUM_GREGS; i++)
      begin
        regs[i] <= decode_pkg::word_t'(i); // r[i] = i after reset
      end
    end
    else if (wr.en)
    begin
      regs[wr.idx] <= wr.data;
    end
  end

  // no write-through, new value shows after the edge
  assign rx = regs[x_idx];
  assign ry = regs[y_idx];

  a_wr_idx_known: assert property (
    @(posedge clk) disable iff (rst)
    wr.en |-> !$isunknown(wr.idx)
  ) else $error("gen_reg_file: write index unknown");

endmodule

// File: verilog/pred_reg_file.sv
module pred_reg_file (
  input  logic                  clk,
  input  logic                  rst,
  input  decode_pkg::preg_wr_t  wr,
  input  decode_pkg::preg_idx_t x_idx,
  input  decode_pkg::preg_idx_t y_idx,
  input  decode_pkg::preg_idx_t guard_idx,
  input  logic                  guard_en,
  output logic                  px,
  output logic                  py,
  output logic                  pval
);

  localparam logic [decode_pkg::NUM_PREGS-1:0] PREG_INIT = 4'b0011; // p0, p1 true

  logic [decode_pkg::NUM_PREGS-1:0] pregs;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pregs <= PREG_INIT;
    end
    else if (wr.en)
    begin
      pregs[wr.idx] <= wr.data;
    end
  end

  assign px = pregs[x_idx];
  assign py = pregs[y_idx];

  // unguarded instructions always execute
  assign pval = guard_en ? pregs[guard_idx] : 1'b1;

  a_wr_idx_known: assert property (
    @(posedge clk) disable iff (rst)
    wr.en |-> !$isunknown(wr.idx)
  ) else $error("pred_reg_file: write index unknown");

endmodule

// File: verilog/decode_stage.sv
module decode_stage (
  input  logic                  clk,
  input  logic                  rst,
  input  decode_pkg::word_t     inst,
  input  decode_pkg::word_t     pc_next,
  input  decode_pkg::greg_wr_t  greg_wr,
  input  decode_pkg::preg_wr_t  preg_wr,
  output decode_pkg::ctrl_t     ctrl,
  output decode_pkg::word_t     rx,
  output decode_pkg::word_t     ry,
  output decode_pkg::word_t     imm,
  output decode_pkg::word_t     jmp_target,
  output logic                  px,
  output logic                  py,
  output logic                  pval,
  output decode_pkg::greg_idx_t x_idx,
  output decode_pkg::greg_idx_t y_idx,
  output decode_pkg::greg_idx_t z_idx
);

  decode_pkg::opcode_e   opcode;
  decode_pkg::greg_idx_t alt_x_idx;
  decode_pkg::preg_idx_t guard_idx;
  logic                  guard_en;

  assign opcode    = decode_pkg::opcode_e'(inst[decode_pkg::OPC_MSB:decode_pkg::OPC_LSB]);
  assign z_idx     = inst[decode_pkg::Z_MSB:decode_pkg::Z_LSB];
  assign y_idx     = inst[decode_pkg::Y_MSB:decode_pkg::Y_LSB];
  assign alt_x_idx = inst[decode_pkg::XA_MSB:decode_pkg::XA_LSB];
  assign guard_en  = inst[decode_pkg::GUARD_EN_BIT];
  assign guard_idx = inst[decode_pkg::GUARD_IDX_MSB:decode_pkg::GUARD_IDX_LSB];

  assign x_idx = ctrl.x_from_z ? z_idx : alt_x_idx; // st, jmpr read z

  control_decoder u_ctrl (
    .opcode (opcode),
    .ctrl   (ctrl)
  );

  gen_reg_file u_gregs (
    .clk   (clk),
    .rst   (rst),
    .wr    (greg_wr),
    .x_idx (x_idx),
    .y_idx (y_idx),
    .rx    (rx),
    .ry    (ry)
  );

  // predicates are addressed by the low index bits
  pred_reg_file u_pregs (
    .clk       (clk),
    .rst       (rst),
    .wr        (preg_wr),
    .x_idx     (x_idx[1:0]),
    .y_idx     (y_idx[1:0]),
    .guard_idx (guard_idx),
    .guard_en  (guard_en),
    .px        (px),
    .py        (py),
    .pval      (pval)
  );

  always_comb
  begin
    case (ctrl.imm_fmt)
      decode_pkg::imm_15: imm = {{17{inst[14]}}, inst[14:0]};
      decode_pkg::imm_23: imm = {{9{inst[22]}}, inst[22:0]};
      decode_pkg::imm_19: imm = {{13{inst[18]}}, inst[18:0]};
      default:            imm = '0;
    endcase
  end

  assign jmp_target = pc_next + imm; // wraps at 32 bits

  // register jumps take their target from rx, never from the immediate
  a_reg_jump_no_imm: assert property (
    @(posedge clk) disable iff (rst)
    ctrl.jmp.reg_target |-> (ctrl.imm_fmt == decode_pkg::imm_none)
  ) else $error("decode_stage: register jump with immediate format %0d", ctrl.imm_fmt);

endmodule

// File: test/tb_decode.sv
module tb_decode;
  timeunit 1ns;
  timeprecision 100ps;

  logic                  clk;
  logic                  rst;
  decode_pkg::word_t     inst;
  decode_pkg::word_t     pc_next;
  decode_pkg::greg_wr_t  greg_wr;
  decode_pkg::preg_wr_t  preg_wr;
  decode_pkg::ctrl_t     ctrl;
  decode_pkg::word_t     rx;
  decode_pkg::word_t     ry;
  decode_pkg::word_t     imm;
  decode_pkg::word_t     jmp_target;
  logic                  px;
  logic                  py;
  logic                  pval;
  decode_pkg::greg_idx_t x_idx;
  decode_pkg::greg_idx_t y_idx;
  decode_pkg::greg_idx_t z_idx;

  int err_count = 0;
  int tests_run = 0;
  int tests_failed = 0;

  decode_stage dut (
    .clk        (clk),
    .rst        (rst),
    .inst       (inst),
    .pc_next    (pc_next),
    .greg_wr    (greg_wr),
    .preg_wr    (preg_wr),
    .ctrl       (ctrl),
    .rx         (rx),
    .ry         (ry),
    .imm        (imm),
    .jmp_target (jmp_target),
    .px         (px),
    .py         (py),
    .pval       (pval),
    .x_idx      (x_idx),
    .y_idx      (y_idx),
    .z_idx      (z_idx)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial
  begin
    #100us;
    $display("timeout: run did not reach its end");
    $display("Simulation FAILED");
    $finish;
  end

  function automatic logic [3:0] alu_code(logic [5:0] opc);
    if (opc inside {6'h23, 6'h24, 6'h27, 6'h14, 6'h0a}) return 4'h1;
    if (opc inside {6'h28, 6'h15, 6'h0b}) return 4'h2;
    if (opc inside {6'h29, 6'h16, 6'h0c}) return 4'h3;
    if (opc inside {6'h2a, 6'h17, 6'h0d}) return 4'h4;
    if (opc inside {6'h26, 6'h18, 6'h0e}) return 4'h5;
    if (opc inside {6'h2b, 6'h19, 6'h0f}) return 4'h6;
    if (opc inside {6'h2c, 6'h1a, 6'h10}) return 4'h7;
    if (opc inside {6'h11, 6'h07}) return 4'h8;
    if (opc inside {6'h12, 6'h08}) return 4'h9;
    if (opc inside {6'h13, 6'h09}) return 4'ha;
    if (opc == 6'h05) return 4'hb;
    if (opc == 6'h06) return 4'hc;
    if (opc == 6'h25) return 4'hd;
    if (opc inside {6'h1b, 6'h1c}) return 4'he;
    return 4'h0;
  endfunction

  // rx ry | wb | mem | link src2 | alu | int | jmp | fmt | x_from_z
  function automatic decode_pkg::ctrl_t ctrl_for(logic [5:0] opc);
    logic [3:0] a;
    a = alu_code(opc);
    if (opc == 6'h23) return {2'b01, 3'b101, 2'b01, 2'b01, a, 1'b1, 2'b00, 2'b01, 1'b0};
    if (opc == 6'h24) return {2'b11, 3'b000, 2'b10, 2'b01, a, 1'b1, 2'b00, 2'b01, 1'b1};
    if (opc inside {[6'h27:6'h2a]})
      return {2'b00, 3'b010, 2'b00, 2'b00, a, 1'b0, 2'b00, 2'b00, 1'b0};
    if (opc inside {6'h26, 6'h2b, 6'h2c})
      return {2'b01, 3'b010, 2'b00, 2'b00, a, 1'b0, 2'b00, 2'b00, 1'b0};
    if (opc == 6'h25) return {2'b00, 3'b100, 2'b00, 2'b01, a, 1'b1, 2'b00, 2'b11, 1'b0};
    if (opc inside {[6'h11:6'h1a]})
      return {2'b01, 3'b100, 2'b00, 2'b01, a, 1'b1, 2'b00, 2'b01, 1'b0};
    if (opc inside {[6'h07:6'h10]})
      return {2'b11, 3'b100, 2'b00, 2'b00, a, 1'b1, 2'b00, 2'b00, 1'b0};
    if (opc inside {6'h05, 6'h06})
      return {2'b01, 3'b100, 2'b00, 2'b00, a, 1'b1, 2'b00, 2'b00, 1'b0};
    if (opc == 6'h1d) return {2'b00, 3'b000, 2'b00, 2'b00, a, 1'b0, 2'b01, 2'b10, 1'b0};
    if (opc == 6'h1e) return {2'b10, 3'b000, 2'b00, 2'b00, a, 1'b0, 2'b11, 2'b00, 1'b1};
    if (opc == 6'h1b) return {2'b00, 3'b100, 2'b00, 2'b10, a, 1'b1, 2'b01, 2'b11, 1'b0};
    if (opc == 6'h1c) return {2'b10, 3'b100, 2'b00, 2'b10, a, 1'b1, 2'b11, 2'b00, 1'b0};
    return '0; // fp and unknown opcodes
  endfunction

  function automatic decode_pkg::word_t imm_for(decode_pkg::word_t w,
                                                decode_pkg::imm_fmt_e fmt);
    case (fmt)
      decode_pkg::imm_15: return {{17{w[14]}}, w[14:0]};
      decode_pkg::imm_23: return {{9{w[22]}}, w[22:0]};
      decode_pkg::imm_19: return {{13{w[18]}}, w[18:0]};
      default:            return '0;
    endcase
  endfunction

  function automatic decode_pkg::word_t make_inst(logic g, logic [1:0] gi, logic [5:0] opc,
                                                  logic [22:0] low);
    return {g, gi, opc, low};
  endfunction

  // reference copy of both register files
  decode_pkg::word_t gmodel [16];
  logic [3:0]        pmodel;

  always @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < 16; i++)
      begin
        gmodel[i] <= 32'(i);
      end
      pmodel <= 4'b0011;
    end
    else
    begin
      if (greg_wr.en)
        gmodel[greg_wr.idx] <= greg_wr.data;
      if (preg_wr.en)
        pmodel[preg_wr.idx] <= preg_wr.data;
    end
  end

  decode_pkg::ctrl_t exp_ctrl;
  decode_pkg::word_t exp_imm;
  decode_pkg::word_t exp_jmp;
  decode_pkg::word_t exp_rx;
  decode_pkg::word_t exp_ry;
  logic [3:0]        exp_x;
  logic [3:0]        exp_y;
  logic [3:0]        exp_z;
  logic              exp_px;
  logic              exp_py;
  logic              exp_pval;

  always_comb
  begin
    exp_ctrl = ctrl_for(inst[28:23]);
    exp_imm  = imm_for(inst, exp_ctrl.imm_fmt);
    exp_jmp  = pc_next + exp_imm;
    exp_x    = (inst[28:23] == 6'h24 || inst[28:23] == 6'h1e) ? inst[22:19] : inst[14:11];
    exp_y    = inst[18:15];
    exp_z    = inst[22:19];
    exp_rx   = gmodel[exp_x];
    exp_ry   = gmodel[exp_y];
    exp_px   = pmodel[exp_x[1:0]];
    exp_py   = pmodel[exp_y[1:0]];
    exp_pval = inst[31] ? pmodel[inst[30:29]] : 1'b1;
  end

  task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] want);
    err_count++;
    $display("mismatch %s: got %h expected %h", name, got, want);
  endtask

  a_ctrl: assert property (@(posedge clk) disable iff (rst) ctrl == exp_ctrl)
    else report_mismatch("ctrl", 32'($sampled(ctrl)), 32'($sampled(exp_ctrl)));
  a_imm: assert property (@(posedge clk) disable iff (rst) imm == exp_imm)
    else report_mismatch("imm", $sampled(imm), $sampled(exp_imm));
  a_jmp: assert property (@(posedge clk) disable iff (rst) jmp_target == exp_jmp)
    else report_mismatch("jmp_target", $sampled(jmp_target), $sampled(exp_jmp));
  a_x_idx: assert property (@(posedge clk) disable iff (rst) x_idx == exp_x)
    else report_mismatch("x_idx", 32'($sampled(x_idx)), 32'($sampled(exp_x)));
  a_y_idx: assert property (@(posedge clk) disable iff (rst) y_idx == exp_y)
    else report_mismatch("y_idx", 32'($sampled(y_idx)), 32'($sampled(exp_y)));
  a_z_idx: assert property (@(posedge clk) disable iff (rst) z_idx == exp_z)
    else report_mismatch("z_idx", 32'($sampled(z_idx)), 32'($sampled(exp_z)));
  a_rx: assert property (@(posedge clk) disable iff (rst) rx == exp_rx)
    else report_mismatch("rx", $sampled(rx), $sampled(exp_rx));
  a_ry: assert property (@(posedge clk) disable iff (rst) ry == exp_ry)
    else report_mismatch("ry", $sampled(ry), $sampled(exp_ry));
  a_px: assert property (@(posedge clk) disable iff (rst) px == exp_px)
    else report_mismatch("px", 32'($sampled(px)), 32'($sampled(exp_px)));
  a_py: assert property (@(posedge clk) disable iff (rst) py == exp_py)
    else report_mismatch("py", 32'($sampled(py)), 32'($sampled(exp_py)));
  a_pval: assert property (@(posedge clk) disable iff (rst) pval == exp_pval)
    else report_mismatch("pval", 32'($sampled(pval)), 32'($sampled(exp_pval)));

  // inputs change 1 ns after the edge
  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic wait_regs_ready();
    int n;
    n = 0;
    while ($isunknown(rx) && n < 10)
    begin
      tick();
      n++;
    end
    if ($isunknown(rx))
    begin
      $display("timeout: register file still unknown after reset");
      err_count++;
    end
  endtask

  task automatic finish_test(string name, int errs_before);
    tests_run++;
    if (err_count == errs_before)
    begin
      $display("test %s: ok", name);
    end
    else
    begin
      tests_failed++;
      $display("test %s: %0d errors", name, err_count - errs_before);
    end
  endtask

  initial
  begin
    int errs;
    logic [3:0] idx;
    logic [5:0] ops [4];

    void'($urandom(32'h3030));
    ops = '{6'h24, 6'h1e, 6'h0a, 6'h23}; // st, jmpr, add, ld
    rst = 1'b1;
    inst = '0;
    pc_next = '0;
    greg_wr = '0;
    preg_wr = '0;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    wait_regs_ready();

    errs = err_count;
    for (int i = 0; i < 16; i++)
    begin
      inst = make_inst(1'b0, 2'b00, 6'h0a, {4'(i), 4'(15 - i), 4'(i), 11'h0});
      tick();
    end
    finish_test("reset_contents", errs);

    errs = err_count;
    repeat (16)
    begin
      idx = 4'($urandom);
      inst = '0;
      greg_wr.en = 1'($urandom);
      greg_wr.idx = idx;
      greg_wr.data = $urandom;
      preg_wr.en = 1'($urandom);
      preg_wr.idx = idx[1:0];
      preg_wr.data = 1'($urandom);
      tick();
      greg_wr.en = 1'b0;
      preg_wr.en = 1'b0;
      inst = make_inst(1'b0, 2'b00, 6'h0a, {4'h0, 4'($urandom), idx, 11'h0}); // read back
      tick();
    end
    finish_test("reg_write", errs);

    errs = err_count;
    pc_next = '0;
    for (int op = 0; op < 64; op++)
    begin
      inst = make_inst(1'b0, 2'b00, 6'(op), 23'h0);
      tick();
    end
    finish_test("ctrl_decode", errs);

    errs = err_count;
    for (int op = 0; op < 64; op++)
    begin
      repeat (4)
      begin
        inst = make_inst(1'b0, 2'b00, 6'(op), 23'($urandom));
        pc_next = $urandom;
        tick();
      end
    end
    finish_test("imm_jump", errs);

    errs = err_count;
    repeat (40)
    begin
      inst = make_inst(1'($urandom), 2'($urandom), ops[2'($urandom)], 23'($urandom));
      tick();
    end
    finish_test("index_guard", errs);

    $display("tests run %0d, tests failed %0d, check errors %0d",
             tests_run, tests_failed, err_count);
    if (err_count == 0)
    begin
      $display("Simulation PASSED");
    end
    else
    begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: build.f
verilog/decode_pkg.sv
verilog/control_decoder.sv
verilog/gen_reg_file.sv
verilog/pred_reg_file.sv
verilog/decode_stage.sv
test/tb_decode.sv

// File: Makefile
# Verilator build and run for the decode stage testbench

TOP       ?= tb_decode
FLIST     ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0
SOURCES   := $(wildcard verilog/*.sv) $(wildcard test/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# the log decides the result, so a run without the pass line fails
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
